//--- Makefile
SRCS := $(wildcard hw/*.sv) $(wildcard testbench/*.sv)

.PHONY: run clean

obj_dir/Vtb_spi_flash_reader: spi_flash_reader.f $(SRCS)
	verilator --binary --timing --top-module tb_spi_flash_reader -f spi_flash_reader.f

run: obj_dir/Vtb_spi_flash_reader
	@out="$$(./obj_dir/Vtb_spi_flash_reader)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- hw/flash_cmd_pkg.sv
package flash_cmd_pkg;

   // address, data and command widths as seen on the flash side
   typedef logic [23:0] flash_addr_t;
   typedef logic [31:0] flash_word_t;
   typedef logic [7:0]  flash_opcode_t;
   typedef logic [1:0]  req_kind_t;

   // request kinds on the request port
   localparam req_kind_t REQ_READ      = 2'd0;
   localparam req_kind_t REQ_FAST_READ = 2'd1;
   localparam req_kind_t REQ_READ_ID   = 2'd2;

   // command bytes
   localparam flash_opcode_t OP_READ      = 8'h03;
   localparam flash_opcode_t OP_FAST_READ = 8'h0B;  // needs 8 dummy bits after the address
   localparam flash_opcode_t OP_READ_ID   = 8'h9F;
   localparam flash_opcode_t OP_WAKE_UP   = 8'hAB;  // release from deep power down

   // one bus transfer as handed from the decoder to the shift engine
   typedef struct packed {
      flash_opcode_t opcode;
      flash_addr_t   addr;
      logic          send_addr;   // 24 address bits follow the opcode
      logic          dummy_byte;  // 8 dummy bits before the data
   } flash_xfer_t;

endpackage

//--- hw/flash_request_decoder.sv
`timescale 1ns/1ps

module flash_request_decoder
   import flash_cmd_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        addr_en,
   input  flash_addr_t addr_data,
   input  req_kind_t   req_kind,
   input  logic        wake_done,
   input  logic        rd_release,
   output logic        addr_buffer_free,
   output logic        start,
   output flash_xfer_t xfer
);

   logic        busy;      // a request is in flight or its result is still held
   logic        accept;
   flash_xfer_t decoded;

   // no request is taken before the flash has woken up
   assign addr_buffer_free = wake_done & ~busy;
   assign accept           = addr_en & addr_buffer_free;

   // map the request kind onto the bus transfer
   always_comb begin
      decoded.addr = addr_data;
      case (req_kind)
         REQ_FAST_READ: begin
            decoded.opcode     = OP_FAST_READ;
            decoded.send_addr  = 1'b1;
            decoded.dummy_byte = 1'b1;
         end
         REQ_READ_ID: begin
            decoded.opcode     = OP_READ_ID;
            decoded.send_addr  = 1'b0;   // id comes straight after the opcode
            decoded.dummy_byte = 1'b0;
         end
         default: begin
            // plain read, also taken for an unknown kind
            decoded.opcode     = OP_READ;
            decoded.send_addr  = 1'b1;
            decoded.dummy_byte = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy  <= 1'b0;
         start <= 1'b0;
      end else begin
         start <= accept;          // one cycle after the strobe
         if (accept) begin
            busy <= 1'b1;
         end else if (rd_release) begin
            busy <= 1'b0;          // result taken, ready for the next request
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         xfer <= decoded;
      end
   end

endmodule

//--- hw/read_data_holder.sv
`timescale 1ns/1ps

module read_data_holder
   import flash_cmd_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        word_done,
   input  flash_word_t word,
   input  logic        rd_ack,
   output logic        rd_data_available,
   output flash_word_t rd_data,
   output logic        rd_release
);

   // ack only counts while a word is held, so this is a single cycle pulse
   assign rd_release = rd_data_available & rd_ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_data_available <= 1'b0;
      end else if (word_done) begin
         rd_data_available <= 1'b1;
      end else if (rd_release) begin
         rd_data_available <= 1'b0;
      end
   end

   // the engine cannot finish another word before the release, so the word stays put
   always_ff @(posedge clk) begin
      if (word_done) begin
         rd_data <= word;
      end
   end

endmodule

//--- hw/spi_flash_reader.sv
`timescale 1ns/1ps

module spi_flash_reader
   import flash_cmd_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // request port
   input  logic        addr_en,
   input  flash_addr_t addr_data,
   input  req_kind_t   req_kind,
   output logic        addr_buffer_free,

   // result port
   output logic        rd_data_available,
   input  logic        rd_ack,
   output flash_word_t rd_data,

   // spi pins, mode 0
   output logic        spi_sck,
   output logic        spi_ss,
   output logic        spi_mosi,
   input  logic        spi_miso
);

   logic        start;
   flash_xfer_t xfer;
   logic        wake_done;
   logic        word_done;
   flash_word_t word;
   logic        rd_release;

   flash_request_decoder u_decoder (
      .clk              (clk),
      .reset            (reset),
      .addr_en          (addr_en),
      .addr_data        (addr_data),
      .req_kind         (req_kind),
      .wake_done        (wake_done),
      .rd_release       (rd_release),
      .addr_buffer_free (addr_buffer_free),
      .start            (start),
      .xfer             (xfer)
   );

   spi_shift_engine u_engine (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .xfer      (xfer),
      .wake_done (wake_done),
      .word_done (word_done),
      .word      (word),
      .spi_sck   (spi_sck),
      .spi_ss    (spi_ss),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso)
   );

   read_data_holder u_holder (
      .clk               (clk),
      .reset             (reset),
      .word_done         (word_done),
      .word              (word),
      .rd_ack            (rd_ack),
      .rd_data_available (rd_data_available),
      .rd_data           (rd_data),
      .rd_release        (rd_release)
   );

endmodule

//--- hw/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine
   import flash_cmd_pkg::*;
   import spi_timing_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        start,
   input  flash_xfer_t xfer,
   output logic        wake_done,
   output logic        word_done,
   output flash_word_t word,
   output logic        spi_sck,
   output logic        spi_ss,
   output logic        spi_mosi,
   input  logic        spi_miso
);

   spi_state_t  state;
   spi_phase_t  phase;         // position inside the current bit
   bit_cnt_t    bit_cnt;       // bit index inside the current segment
   wake_cnt_t   wait_cnt;
   logic [31:0] shreg;         // opcode then address, msb leaves first
   logic        send_addr_q;
   logic        dummy_q;

   logic        launch;
   logic        bit_end;
   logic        seg_last;
   logic        sample;
   logic [31:0] launch_word;

   // the first cycle after reset starts the wake-up, later ones start on request
   assign launch      = (state == WAKE_SEND && spi_ss) || (state == IDLE && start);
   assign launch_word = (state == IDLE) ? {xfer.opcode, xfer.addr} : {OP_WAKE_UP, 24'h0};

   assign bit_end = ~spi_ss && phase == spi_phase_t'(BIT_CLKS - 1);
   assign sample  = ~spi_ss && state == RECEIVE && phase == spi_phase_t'(MISO_SAMPLE_PHASE);

   // last bit index of each segment
   always_comb begin
      case (state)
         SEND_ADDR: seg_last = bit_cnt == bit_cnt_t'(23);
         RECEIVE:   seg_last = bit_cnt == bit_cnt_t'(31);
         default:   seg_last = bit_cnt == bit_cnt_t'(7);   // opcode, dummy and wake-up
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= WAKE_SEND;
         phase     <= '0;
         bit_cnt   <= '0;
         wait_cnt  <= '0;
         spi_ss    <= 1'b1;
         spi_sck   <= 1'b0;
         spi_mosi  <= 1'b0;
         wake_done <= 1'b0;
         word_done <= 1'b0;
      end else begin
         word_done <= 1'b0;

         if (launch) begin
            // select the slave and put the first bit out, this is phase 0
            spi_ss   <= 1'b0;
            spi_sck  <= 1'b0;
            spi_mosi <= launch_word[31];
            phase    <= '0;
            bit_cnt  <= '0;
            if (state == IDLE) begin
               state <= SEND_CMD;
            end
         end else if (~spi_ss) begin
            phase <= phase + 1'b1;
            if (phase == spi_phase_t'(SCK_RISE_PHASE - 1)) begin
               spi_sck <= 1'b1;
            end

            if (bit_end) begin
               spi_sck <= 1'b0;   // falling edge together with the next mosi bit
               phase   <= '0;
               bit_cnt <= bit_cnt + 1'b1;

               if (!seg_last) begin
                  // dummy and data bits keep mosi low
                  spi_mosi <= (state == DUMMY || state == RECEIVE) ? 1'b0 : shreg[31];
               end else begin
                  bit_cnt  <= '0;
                  spi_mosi <= 1'b0;
                  case (state)
                     WAKE_SEND: begin
                        spi_ss <= 1'b1;
                        state  <= WAKE_WAIT;
                     end
                     SEND_CMD: begin
                        if (send_addr_q) begin
                           spi_mosi <= shreg[31];   // address msb
                           state    <= SEND_ADDR;
                        end else if (dummy_q) begin
                           state <= DUMMY;
                        end else begin
                           state <= RECEIVE;
                        end
                     end
                     SEND_ADDR: state <= dummy_q ? DUMMY : RECEIVE;
                     DUMMY:     state <= RECEIVE;
                     RECEIVE: begin
                        spi_ss    <= 1'b1;   // word complete, release the bus
                        word_done <= 1'b1;
                        state     <= IDLE;
                     end
                     default: state <= IDLE;
                  endcase
               end
            end
         end else if (state == WAKE_WAIT) begin
            wait_cnt <= wait_cnt + 1'b1;
            if (wait_cnt == wake_cnt_t'(WAKE_WAIT_CLKS - 1)) begin
               wait_cnt  <= '0;
               wake_done <= 1'b1;   // stays high from here on
               state     <= IDLE;
            end
         end
      end
   end

   // shift register, transfer flags and received word
   always_ff @(posedge clk) begin
      if (launch) begin
         shreg <= {launch_word[30:0], 1'b0};
         if (state == IDLE) begin
            send_addr_q <= xfer.send_addr;
            dummy_q     <= xfer.dummy_byte;
         end
      end else if (bit_end) begin
         shreg <= {shreg[30:0], 1'b0};
      end

      if (sample) begin
         word <= {word[30:0], spi_miso};   // msb arrives first
      end
   end

endmodule

//--- hw/spi_timing_pkg.sv
package spi_timing_pkg;

   // one spi bit spans this many system clocks
   localparam int BIT_CLKS          = 8;
   localparam int SCK_RISE_PHASE    = 4;   // sck falls again at phase 0
   localparam int MISO_SAMPLE_PHASE = 6;

   // settling time after the wake-up opcode
   localparam int WAKE_WAIT_CLKS    = 256;

   typedef logic [$clog2(BIT_CLKS)-1:0]       spi_phase_t;
   typedef logic [4:0]                        bit_cnt_t;   // up to 32 bits per segment
   typedef logic [$clog2(WAKE_WAIT_CLKS)-1:0] wake_cnt_t;

   typedef enum logic [2:0] {
      WAKE_SEND,
      WAKE_WAIT,
      IDLE,
      SEND_CMD,
      SEND_ADDR,
      DUMMY,
      RECEIVE
   } spi_state_t;

endpackage

//--- spi_flash_reader.f
hw/flash_cmd_pkg.sv
hw/spi_timing_pkg.sv
hw/flash_request_decoder.sv
hw/spi_shift_engine.sv
hw/read_data_holder.sv
hw/spi_flash_reader.sv
testbench/spi_flash_model.sv
testbench/tb_spi_flash_reader.sv

//--- testbench/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model
   import flash_cmd_pkg::*;
(
   input  logic spi_sck,
   input  logic spi_ss,
   input  logic spi_mosi,
   output logic spi_miso
);

   localparam flash_word_t ID_WORD = 32'h20BA1810;

   int            bit_cnt;        // bits seen in the current select
   int            data_start;     // first bit index driven on miso
   logic          in_select;
   flash_opcode_t opcode;
   flash_addr_t   addr;
   flash_word_t   data_word;

   // observed by the testbench
   flash_opcode_t last_opcode;
   int            last_bits;
   int            select_count;
   realtime       last_rise;
   realtime       min_gap;
   realtime       max_gap;

   function automatic flash_word_t word_for(flash_opcode_t op, flash_addr_t a);
      if (op == OP_READ_ID) begin
         return ID_WORD;
      end
      return {a ^ 24'h5A5A5A, a[7:0]};
   endfunction

   initial begin
      spi_miso     = 1'b0;
      in_select    = 1'b0;
      select_count = 0;
      last_bits    = 0;
      last_opcode  = '0;
   end

   always @(negedge spi_ss) begin
      in_select    = 1'b1;
      select_count = select_count + 1;   // counted as soon as the select opens
      bit_cnt      = 0;
      opcode       = '0;
      addr         = '0;
      data_start   = 1000;   // nothing driven until the opcode is known
      min_gap      = 0;
      max_gap      = 0;
   end

   always @(posedge spi_ss) begin
      if (in_select) begin
         in_select    = 1'b0;
         last_bits    = bit_cnt;
         last_opcode  = opcode;
      end
      spi_miso = 1'b0;
   end

   always @(posedge spi_sck) begin
      if (!spi_ss) begin
         if (bit_cnt > 0) begin
            if (bit_cnt == 1 || ($realtime - last_rise) < min_gap) min_gap = $realtime - last_rise;
            if (($realtime - last_rise) > max_gap) max_gap = $realtime - last_rise;
         end
         last_rise = $realtime;
         if (bit_cnt < 8) begin
            opcode = {opcode[6:0], spi_mosi};
         end else if (bit_cnt < 32 && opcode != OP_READ_ID) begin
            addr = {addr[22:0], spi_mosi};
         end
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            case (opcode)
               OP_READ:      data_start = 32;
               OP_FAST_READ: data_start = 40;   // 8 dummy bits skipped
               OP_READ_ID:   data_start = 8;
               default:      data_start = 1000;
            endcase
         end
      end
   end

   // mode 0, next bit goes out on the falling edge
   always @(negedge spi_sck) begin
      if (!spi_ss && bit_cnt >= data_start && bit_cnt < data_start + 32) begin
         data_word = word_for(opcode, addr);
         spi_miso  = data_word[31 - (bit_cnt - data_start)];
      end
   end

endmodule

//--- testbench/tb_spi_flash_reader.sv
`timescale 1ns/1ps

module tb_spi_flash_reader
   import flash_cmd_pkg::*;
   import spi_timing_pkg::*;
;

   localparam int CLK_PERIOD    = 100;
   localparam int NUM_TESTS     = 20;
   localparam int MAX_ACK_DELAY = 15;
   localparam int WATCHDOG_CYCLES = 16 + 8 * BIT_CLKS + WAKE_WAIT_CLKS
                                  + NUM_TESTS * (72 * BIT_CLKS + MAX_ACK_DELAY) + 2000;

   typedef struct packed {
      req_kind_t   kind;
      flash_addr_t addr;
      logic [3:0]  ack_delay;   // cycles before rd_ack
      logic        stray;       // extra addr_en while the word is held
   } test_entry_t;

   logic        clk;
   logic        reset;
   logic        addr_en;
   flash_addr_t addr_data;
   req_kind_t   req_kind;
   logic        addr_buffer_free;
   logic        rd_data_available;
   logic        rd_ack;
   flash_word_t rd_data;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;
   logic        spi_miso;

   test_entry_t entries [NUM_TESTS];
   string       test_names [NUM_TESTS];

   spi_flash_reader u_spi_flash_reader (.*);

   spi_flash_model u_flash_model (
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(string reason);
      $display("Test failures found");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_word(string name, flash_word_t exp, flash_word_t act);
      if (exp !== act) begin
         $display("Error: %s expected %h actual %h", name, exp, act);
         abort_run("wrong data word");
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (exp !== act) begin
         $display("Error: %s expected %b actual %b", name, exp, act);
         abort_run("wrong flag value");
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      if (exp != act) begin
         $display("Error: %s expected %0d actual %0d", name, exp, act);
         abort_run("wrong count");
      end
   endtask

   // expected values straight from the flash rules
   function automatic flash_word_t expected_word(req_kind_t kind, flash_addr_t a);
      if (kind == REQ_READ_ID) return 32'h20BA1810;
      return {a ^ 24'h5A5A5A, a[7:0]};
   endfunction

   function automatic int expected_opcode(req_kind_t kind);
      if (kind == REQ_FAST_READ) return 'h0B;
      if (kind == REQ_READ_ID) return 'h9F;
      return 'h03;   // unknown kind reads plainly
   endfunction

   function automatic int expected_bits(req_kind_t kind);
      if (kind == REQ_FAST_READ) return 72;
      if (kind == REQ_READ_ID) return 40;
      return 64;
   endfunction

   task automatic set_entry(int idx, string name, req_kind_t kind, flash_addr_t a,
                            int delay, logic stray);
      test_names[idx]         = name;
      entries[idx].kind       = kind;
      entries[idx].addr       = a;
      entries[idx].ack_delay  = 4'(delay);
      entries[idx].stray      = stray;
   endtask

   task automatic build_table();
      flash_addr_t rnd [4];
      for (int i = 0; i < 4; i++) rnd[i] = flash_addr_t'($urandom());
      set_entry(0,  "read_zero",        REQ_READ,      24'h000000, 0,  1'b0);
      set_entry(1,  "read_ones",        REQ_READ,      24'hFFFFFF, 1,  1'b0);
      set_entry(2,  "read_alt",         REQ_READ,      24'hA5A5A5, 0,  1'b0);
      set_entry(3,  "read_rand0",       REQ_READ,      rnd[0],     2,  1'b0);
      set_entry(4,  "fast_read_low",    REQ_FAST_READ, 24'h000100, 0,  1'b0);
      set_entry(5,  "fast_read_rand1",  REQ_FAST_READ, rnd[1],     3,  1'b0);
      set_entry(6,  "read_id_0",        REQ_READ_ID,   24'h123456, 0,  1'b0);
      set_entry(7,  "read_hold_stray",  REQ_READ,      24'h5A5A5A, 12, 1'b1);
      set_entry(8,  "read_after_stray", REQ_READ,      24'h00FF00, 0,  1'b0);
      set_entry(9,  "fast_hold",        REQ_FAST_READ, 24'h7FFFFF, 8,  1'b0);
      set_entry(10, "read_id_hold",     REQ_READ_ID,   24'h000000, 6,  1'b1);
      set_entry(11, "read_rand2",       REQ_READ,      rnd[2],     0,  1'b0);
      set_entry(12, "fast_read_rand3",  REQ_FAST_READ, rnd[3],     1,  1'b0);
      set_entry(13, "read_kind3",       2'd3,          24'h0ABCDE, 0,  1'b0);
      set_entry(14, "fast_stray",       REQ_FAST_READ, 24'h800001, 10, 1'b1);
      set_entry(15, "read_id_1",        REQ_READ_ID,   24'hFFFFFF, 0,  1'b0);
      set_entry(16, "read_top",         REQ_READ,      24'hFFFFFE, 2,  1'b0);
      set_entry(17, "fast_mid",         REQ_FAST_READ, 24'h3C3C3C, 0,  1'b0);
      set_entry(18, "read_back2back",   REQ_READ,      24'h000001, 0,  1'b0);
      set_entry(19, "read_last",        REQ_READ,      24'h654321, 4,  1'b0);
   endtask

   task automatic run_entry(int idx);
      test_entry_t e;
      string       name;
      int          sel_before;
      flash_word_t held;
      e          = entries[idx];
      name       = test_names[idx];
      sel_before = u_flash_model.select_count;
      @(negedge clk);
      while (!addr_buffer_free) @(negedge clk);
      @(posedge clk);
      #1;
      addr_en   = 1'b1;
      addr_data = e.addr;
      req_kind  = e.kind;
      @(posedge clk);
      #1 addr_en = 1'b0;
      @(negedge clk);
      check_flag({name, " busy"}, 1'b0, addr_buffer_free);
      while (!rd_data_available) @(negedge clk);
      check_count({name, " selects"}, sel_before + 1, u_flash_model.select_count);
      check_count({name, " opcode"}, expected_opcode(e.kind), int'(u_flash_model.last_opcode));
      check_count({name, " bits"}, expected_bits(e.kind), u_flash_model.last_bits);
      check_count({name, " min sck gap"}, BIT_CLKS * CLK_PERIOD, int'(u_flash_model.min_gap));
      check_count({name, " max sck gap"}, BIT_CLKS * CLK_PERIOD, int'(u_flash_model.max_gap));
      check_word(name, expected_word(e.kind, e.addr), rd_data);
      held = rd_data;
      // hold the word and check that nothing moves
      for (int d = 0; d < int'(e.ack_delay); d++) begin
         @(posedge clk);
         #1;
         addr_en   = e.stray && d == 0;
         addr_data = ~e.addr;
         req_kind  = REQ_READ_ID;
         @(negedge clk);
         check_flag({name, " held avail"}, 1'b1, rd_data_available);
         check_flag({name, " held free"}, 1'b0, addr_buffer_free);
         check_word({name, " held data"}, held, rd_data);
      end
      @(posedge clk);
      #1;
      addr_en = 1'b0;
      rd_ack  = 1'b1;
      @(posedge clk);
      #1 rd_ack = 1'b0;
      @(negedge clk);
      check_flag({name, " free after ack"}, 1'b1, addr_buffer_free);
      check_flag({name, " avail after ack"}, 1'b0, rd_data_available);
      check_count({name, " no stray select"}, sel_before + 1, u_flash_model.select_count);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("run timed out with a result still outstanding");
   end

   initial begin
      void'($urandom(83));
      clk         = 1'b0;
      reset       = 1'b1;
      addr_en     = 1'b0;
      addr_data   = '0;
      req_kind    = REQ_READ;
      rd_ack      = 1'b0;
      build_table();
      repeat (15) @(posedge clk);
      @(negedge clk);
      check_flag("reset ss", 1'b1, spi_ss);
      check_flag("reset sck", 1'b0, spi_sck);
      check_flag("reset mosi", 1'b0, spi_mosi);
      check_flag("reset free", 1'b0, addr_buffer_free);
      check_flag("reset avail", 1'b0, rd_data_available);
      @(posedge clk);
      #1 reset = 1'b0;
      while (!addr_buffer_free) @(negedge clk);   // wake-up done
      check_count("wake selects", 1, u_flash_model.select_count);
      check_count("wake opcode", 'hAB, int'(u_flash_model.last_opcode));
      check_count("wake bits", 8, u_flash_model.last_bits);
      for (int i = 0; i < NUM_TESTS; i++) run_entry(i);
      $display("All tests passed!");
      $finish;
   end

endmodule
